/* source/raycast_pkg.sv */
package raycast_pkg;

    typedef logic [15:0] pixel_t;                         // rgb565 colour
    typedef logic [15:0] addr_t;                          // frame buffer word address

    localparam int REC_W = 38;                            // dda column record width

    // record layout, low bit of each field
    localparam int HCOUNT_LSB    = 29;                    // screen column, 9 bits
    localparam int HCOUNT_W      = 9;
    localparam int HEIGHT_LSB    = 21;                    // line height, 8 bits
    localparam int HEIGHT_W      = 8;
    localparam int WALL_TYPE_BIT = 20;                    // 0 x side, 1 y side
    localparam int MAP_LSB       = 16;                    // map cell code, 4 bits
    localparam int MAP_W         = 4;
    localparam int WALLX_LSB     = 0;                     // fractional hit position
    localparam int WALLX_W       = 16;

    localparam pixel_t BACKGROUND_COLOR = 16'hFFFF;       // sky / floor
    localparam pixel_t BLACK_WALL       = 16'h0000;
    localparam pixel_t GREEN_WALL       = 16'h7670;
    localparam pixel_t SHADE_MASK       = 16'h7BEF;       // drops the bits shifted across fields

    localparam logic [3:0] MAP_FLAT_LAST = 4'd2;          // codes 0..2 are flat
    localparam logic [3:0] MAP_TEX_FIRST = 4'd3;          // codes 3..5 are textured
    localparam logic [3:0] MAP_TEX_LAST  = 4'd5;

endpackage

/* source/column_sequencer.sv */
`timescale 1ns/1ps

module column_sequencer #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic                          pixel_clk_in,
    input  logic                          rst_in,
    input  logic                          dda_fifo_tvalid_in,
    input  logic [raycast_pkg::REC_W-1:0] dda_fifo_tdata_in,
    input  logic                          dda_fifo_tlast_in,
    input  logic                          fb_swap_ready_in,
    output logic                          transformer_tready_out,
    output logic                          issue_valid,       // one row per clock while flattening
    output logic [9:0]                    row,
    output logic [9:0]                    draw_start,
    output logic [9:0]                    draw_end,
    output logic [3:0]                    map_code,
    output logic                          wall_type,
    output logic [15:0]                   wall_x,
    output raycast_pkg::addr_t            row_addr,
    output logic                          row_last
);
    import raycast_pkg::*;

    localparam logic [9:0] HALF_H   = 10'(SCREEN_HEIGHT / 2);
    localparam logic [9:0] LAST_ROW = 10'(SCREEN_HEIGHT - 1);

    typedef enum logic [1:0] {
        S_WAIT,                                             // idle, any record accepted
        S_WAIT_FRAME,                                       // frame done, need swap ready
        S_FLATTEN                                           // walking rows of held record
    } state_t;

    state_t           state;
    logic [REC_W-1:0] rec_q;                                // record being flattened
    logic             tlast_q;                              // record closes the frame
    logic [9:0]       row_cnt;
    logic             accept;
    logic             last_row;

    logic [HCOUNT_W-1:0] hcount;
    logic [9:0]          half_len;
    logic [9:0]          ds_next;
    logic [9:0]          de_next;
    addr_t               addr_next;

    // handshake, swap ready only matters once a frame has ended
    assign accept = dda_fifo_tvalid_in && transformer_tready_out &&
                    ((state == S_WAIT) || (state == S_WAIT_FRAME && fb_swap_ready_in));
    assign last_row = (row_cnt == LAST_ROW);

    assign hcount    = rec_q[HCOUNT_LSB +: HCOUNT_W];
    assign half_len  = 10'(rec_q[HEIGHT_LSB +: HEIGHT_W] >> 1);
    assign ds_next   = HALF_H - half_len;                   // top of wall slice
    assign de_next   = HALF_H + half_len;                   // one past bottom
    assign addr_next = addr_t'(int'(hcount) + int'(row_cnt) * SCREEN_WIDTH);

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state                  <= S_WAIT;
            transformer_tready_out <= 1'b1;                 // ready straight out of reset
            row_cnt                <= '0;
            issue_valid            <= 1'b0;
        end else begin
            issue_valid <= (state == S_FLATTEN);            // issue row_cnt this edge
            case (state)
                S_WAIT, S_WAIT_FRAME: begin
                    if (accept) begin
                        transformer_tready_out <= 1'b0;     // hold off until rows are out
                        row_cnt                <= '0;
                        state                  <= S_FLATTEN;
                    end
                end
                S_FLATTEN: begin
                    if (last_row) begin
                        transformer_tready_out <= 1'b1;
                        row_cnt                <= '0;
                        state                  <= tlast_q ? S_WAIT_FRAME : S_WAIT;
                    end else begin
                        row_cnt <= row_cnt + 10'd1;
                    end
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    // record capture on the accept edge
    always_ff @(posedge pixel_clk_in) begin
        if (accept) begin
            rec_q   <= dda_fifo_tdata_in;
            tlast_q <= dda_fifo_tlast_in;
        end
    end

    // per-row fields, only meaningful with issue_valid
    always_ff @(posedge pixel_clk_in) begin
        row        <= row_cnt;
        draw_start <= ds_next;
        draw_end   <= de_next;
        map_code   <= rec_q[MAP_LSB +: MAP_W];
        wall_type  <= rec_q[WALL_TYPE_BIT];
        wall_x     <= rec_q[WALLX_LSB +: WALLX_W];
        row_addr   <= addr_next;
        row_last   <= tlast_q && last_row;                  // final row of frame's last column
    end

endmodule

/* source/flat_shader.sv */
`timescale 1ns/1ps

module flat_shader (
    input  logic                pixel_clk_in,
    input  logic                rst_in,
    input  logic                issue_valid,
    input  logic [9:0]          row,
    input  logic [9:0]          draw_start,
    input  logic [9:0]          draw_end,
    input  logic [3:0]          map_code,
    input  logic                wall_type,
    input  raycast_pkg::addr_t  row_addr,
    input  logic                row_last,
    output logic                flat_valid,
    output raycast_pkg::pixel_t flat_pixel,
    output logic                flat_wall_type,
    output logic                flat_in_span,       // in span with a nonzero code
    output logic                flat_tex_select,    // code is a texture
    output raycast_pkg::addr_t  flat_addr,
    output logic                flat_last
);
    import raycast_pkg::*;

    logic       s1_valid;
    logic       s1_in_span;
    logic [3:0] s1_code;
    logic       s1_tex;
    logic       s1_wall;
    addr_t      s1_addr;
    logic       s1_last;
    pixel_t     wall_colour;

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            s1_valid   <= 1'b0;
            flat_valid <= 1'b0;
        end else begin
            s1_valid   <= issue_valid;
            flat_valid <= s1_valid;
        end
    end

    // stage one, span test and code decode
    always_ff @(posedge pixel_clk_in) begin
        s1_in_span <= (row >= draw_start) && (row < draw_end);
        s1_code    <= map_code;
        s1_tex     <= (map_code >= MAP_TEX_FIRST) && (map_code <= MAP_TEX_LAST);
        s1_wall    <= wall_type;
        s1_addr    <= row_addr;
        s1_last    <= row_last;
    end

    // only codes 1 and 2 have a flat colour of their own
    always_comb begin
        case (s1_code)
            4'd1:          wall_colour = BLACK_WALL;
            MAP_FLAT_LAST: wall_colour = GREEN_WALL;
            default:       wall_colour = BACKGROUND_COLOR;
        endcase
    end

    // stage two, colour pick and sideband kept in step with texture path
    always_ff @(posedge pixel_clk_in) begin
        flat_pixel      <= s1_in_span ? wall_colour : BACKGROUND_COLOR;
        flat_in_span    <= s1_in_span && (s1_code != 4'd0);
        flat_tex_select <= s1_tex;
        flat_wall_type  <= s1_wall;
        flat_addr       <= s1_addr;
        flat_last       <= s1_last;
    end

endmodule

/* source/texture_sampler.sv */
`timescale 1ns/1ps

module texture_sampler (
    input  logic                pixel_clk_in,
    input  logic                rst_in,
    input  logic                issue_valid,
    input  logic [9:0]          row,
    input  logic [9:0]          draw_start,
    input  logic [3:0]          map_code,
    input  logic [15:0]         wall_x,
    output logic                tex_valid,
    output raycast_pkg::pixel_t tex_pixel
);
    import raycast_pkg::*;

    localparam int ROM_DEPTH = 768;                         // 3 textures of 16x16

    pixel_t     tex_rom [0:ROM_DEPTH-1];
    logic       s1_valid;
    logic [9:0] s1_index;                                   // {id, u, v}
    logic       is_tex;
    logic [1:0] tex_id;
    logic [3:0] tex_u;
    logic [3:0] tex_v;
    logic [9:0] span_off;

    // fixed texel rule stands in for texture images
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            tex_rom[i] = pixel_t'(((i >> 8) << 12) + (((i >> 4) & 15) << 8) +
                                  ((i & 15) << 4) + (((i >> 4) & 15) ^ (i & 15)));
        end
    end

    assign is_tex   = (map_code >= MAP_TEX_FIRST) && (map_code <= MAP_TEX_LAST);
    assign tex_id   = is_tex ? 2'(map_code - MAP_TEX_FIRST) : 2'd0;  // merge drops non-tex rows
    assign tex_u    = wall_x[15:12];                        // coarse hit position across wall
    assign span_off = row - draw_start;
    assign tex_v    = span_off[3:0];                        // texture tiles every 16 rows

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            s1_valid  <= 1'b0;
            tex_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            tex_valid <= s1_valid;
        end
    end

    // stage one index, stage two rom read
    always_ff @(posedge pixel_clk_in) begin
        s1_index  <= {tex_id, tex_u, tex_v};
        tex_pixel <= tex_rom[s1_index];
    end

endmodule

/* source/pixel_merge.sv */
`timescale 1ns/1ps

module pixel_merge (
    input  logic                pixel_clk_in,
    input  logic                rst_in,
    input  logic                flat_valid,
    input  raycast_pkg::pixel_t flat_pixel,
    input  logic                flat_wall_type,
    input  logic                flat_in_span,
    input  logic                flat_tex_select,
    input  raycast_pkg::addr_t  flat_addr,
    input  logic                flat_last,
    input  logic                tex_valid,
    input  raycast_pkg::pixel_t tex_pixel,
    output logic                ray_valid_out,
    output raycast_pkg::addr_t  ray_address_out,
    output raycast_pkg::pixel_t ray_pixel_out,
    output logic                ray_last_pixel_out
);
    import raycast_pkg::*;

    logic   use_tex;
    logic   shade;
    pixel_t base_pixel;
    pixel_t out_pixel;

    // both paths are the same depth, so tex_valid lines up with flat_valid
    assign use_tex    = flat_tex_select && flat_in_span && tex_valid;
    assign base_pixel = use_tex ? tex_pixel : flat_pixel;
    assign shade      = flat_wall_type && flat_in_span;     // y side hits are drawn darker
    assign out_pixel  = shade ? ((base_pixel >> 1) & SHADE_MASK) : base_pixel;

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            ray_valid_out      <= 1'b0;
            ray_last_pixel_out <= 1'b0;
        end else begin
            ray_valid_out      <= flat_valid;
            ray_last_pixel_out <= flat_last;                // final row of a frame's last column
        end
    end

    // write payload
    always_ff @(posedge pixel_clk_in) begin
        ray_address_out <= flat_addr;
        ray_pixel_out   <= out_pixel;
    end

endmodule

/* source/column_render_top.sv */
`timescale 1ns/1ps

module column_render_top #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic                          pixel_clk_in,
    input  logic                          rst_in,
    input  logic                          dda_fifo_tvalid_in,
    input  logic [raycast_pkg::REC_W-1:0] dda_fifo_tdata_in,
    input  logic                          dda_fifo_tlast_in,
    input  logic                          fb_swap_ready_in,   // frame buffer may start a new frame
    output logic                          transformer_tready_out,
    output logic                          ray_valid_out,
    output raycast_pkg::addr_t            ray_address_out,
    output raycast_pkg::pixel_t           ray_pixel_out,
    output logic                          ray_last_pixel_out
);
    import raycast_pkg::*;

    logic       issue_valid;                                // sequencer to both shaders
    logic [9:0] row;
    logic [9:0] draw_start;
    logic [9:0] draw_end;
    logic [3:0] map_code;
    logic       wall_type;
    logic [15:0] wall_x;
    addr_t      row_addr;
    logic       row_last;

    logic       flat_valid;                                 // flat shader to merge
    pixel_t     flat_pixel;
    logic       flat_wall_type;
    logic       flat_in_span;
    logic       flat_tex_select;
    addr_t      flat_addr;
    logic       flat_last;

    logic       tex_valid;                                  // texture path to merge
    pixel_t     tex_pixel;

    column_sequencer #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) u_seq (
        .pixel_clk_in          (pixel_clk_in),
        .rst_in                (rst_in),
        .dda_fifo_tvalid_in    (dda_fifo_tvalid_in),
        .dda_fifo_tdata_in     (dda_fifo_tdata_in),
        .dda_fifo_tlast_in     (dda_fifo_tlast_in),
        .fb_swap_ready_in      (fb_swap_ready_in),
        .transformer_tready_out(transformer_tready_out),
        .issue_valid           (issue_valid),
        .row                   (row),
        .draw_start            (draw_start),
        .draw_end              (draw_end),
        .map_code              (map_code),
        .wall_type             (wall_type),
        .wall_x                (wall_x),
        .row_addr              (row_addr),
        .row_last              (row_last)
    );

    flat_shader u_flat (
        .pixel_clk_in   (pixel_clk_in),
        .rst_in         (rst_in),
        .issue_valid    (issue_valid),
        .row            (row),
        .draw_start     (draw_start),
        .draw_end       (draw_end),
        .map_code       (map_code),
        .wall_type      (wall_type),
        .row_addr       (row_addr),
        .row_last       (row_last),
        .flat_valid     (flat_valid),
        .flat_pixel     (flat_pixel),
        .flat_wall_type (flat_wall_type),
        .flat_in_span   (flat_in_span),
        .flat_tex_select(flat_tex_select),
        .flat_addr      (flat_addr),
        .flat_last      (flat_last)
    );

    texture_sampler u_tex (
        .pixel_clk_in(pixel_clk_in),
        .rst_in      (rst_in),
        .issue_valid (issue_valid),
        .row         (row),
        .draw_start  (draw_start),
        .map_code    (map_code),
        .wall_x      (wall_x),
        .tex_valid   (tex_valid),
        .tex_pixel   (tex_pixel)
    );

    pixel_merge u_merge (
        .pixel_clk_in      (pixel_clk_in),
        .rst_in            (rst_in),
        .flat_valid        (flat_valid),
        .flat_pixel        (flat_pixel),
        .flat_wall_type    (flat_wall_type),
        .flat_in_span      (flat_in_span),
        .flat_tex_select   (flat_tex_select),
        .flat_addr         (flat_addr),
        .flat_last         (flat_last),
        .tex_valid         (tex_valid),
        .tex_pixel         (tex_pixel),
        .ray_valid_out     (ray_valid_out),
        .ray_address_out   (ray_address_out),
        .ray_pixel_out     (ray_pixel_out),
        .ray_last_pixel_out(ray_last_pixel_out)
    );

endmodule

/* tests/column_render_chk.sv */
`timescale 1ns/1ps

module column_render_chk #(
    parameter int SCREEN_HEIGHT = 180
) (
    input logic                          pixel_clk_in,
    input logic                          rst_in,
    input logic                          dda_fifo_tvalid_in,
    input logic                          dda_fifo_tlast_in,
    input logic                          fb_swap_ready_in,
    input logic                          transformer_tready_out,
    input logic                          ray_valid_out,
    input logic                          ray_last_pixel_out,
    input logic                          issue_valid,         // sequencer row strobe
    input logic [9:0]                    row
);
    logic frame_pending;                                        // frame closed, next needs swap
    logic accepted;

    assign accepted = dda_fifo_tvalid_in && transformer_tready_out &&
                      (!frame_pending || fb_swap_ready_in);

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            frame_pending <= 1'b0;
        end else if (accepted) begin
            frame_pending <= dda_fifo_tlast_in;                 // tlast record ends the frame
        end
    end

    // every row but the last one is issued with tready low
    a_busy_while_flatten: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        issue_valid && (row != 10'(SCREEN_HEIGHT - 1)) |-> !transformer_tready_out)
        else $error("tready high while a column is still being flattened");

    a_busy_after_accept: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        accepted |=> !transformer_tready_out)
        else $error("tready did not drop after a record was taken");

    a_last_with_valid: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        ray_last_pixel_out |-> ray_valid_out)
        else $error("last pixel flag without a pixel write");

    // offer in wait-new-frame without swap ready must leave the record in place
    a_hold_for_swap: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        frame_pending && dda_fifo_tvalid_in && transformer_tready_out && !fb_swap_ready_in
        |=> transformer_tready_out)
        else $error("record taken before the frame buffer was ready to swap");

endmodule

bind column_render_top column_render_chk #(
    .SCREEN_HEIGHT(SCREEN_HEIGHT)
) u_chk (
    .pixel_clk_in          (pixel_clk_in),
    .rst_in                (rst_in),
    .dda_fifo_tvalid_in    (dda_fifo_tvalid_in),
    .dda_fifo_tlast_in     (dda_fifo_tlast_in),
    .fb_swap_ready_in      (fb_swap_ready_in),
    .transformer_tready_out(transformer_tready_out),
    .ray_valid_out         (ray_valid_out),
    .ray_last_pixel_out    (ray_last_pixel_out),
    .issue_valid           (issue_valid),
    .row                   (row)
);

/* tests/column_render_tb.sv */
`timescale 1ns/1ps

module column_render_tb;
    import raycast_pkg::*;

    localparam int SCREEN_WIDTH    = 64;
    localparam int SCREEN_HEIGHT   = 24;
    localparam int NUM_RECORDS     = 37;                        // all phases together
    localparam int WATCHDOG_CYCLES = NUM_RECORDS * (SCREEN_HEIGHT + 8) + 200;

    logic             pixel_clk_in;
    logic             rst_in;
    logic             dda_fifo_tvalid_in;
    logic [REC_W-1:0] dda_fifo_tdata_in;
    logic             dda_fifo_tlast_in;
    logic             fb_swap_ready_in;
    logic             transformer_tready_out;
    logic             ray_valid_out;
    addr_t            ray_address_out;
    pixel_t           ray_pixel_out;
    logic             ray_last_pixel_out;

    integer seed = 32'heac0_abe5;
    int     pix_errors = 0;
    int     addr_errors = 0;
    int     last_errors = 0;
    int     other_errors = 0;
    bit     waiting_frame = 1'b0;                               // last record had tlast
    int     col = 0;

    addr_t  exp_addr [$];                                       // expected writes, in order
    pixel_t exp_pix [$];
    bit     exp_last [$];

    column_render_top #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) dut (
        .pixel_clk_in          (pixel_clk_in),
        .rst_in                (rst_in),
        .dda_fifo_tvalid_in    (dda_fifo_tvalid_in),
        .dda_fifo_tdata_in     (dda_fifo_tdata_in),
        .dda_fifo_tlast_in     (dda_fifo_tlast_in),
        .fb_swap_ready_in      (fb_swap_ready_in),
        .transformer_tready_out(transformer_tready_out),
        .ray_valid_out         (ray_valid_out),
        .ray_address_out       (ray_address_out),
        .ray_pixel_out         (ray_pixel_out),
        .ray_last_pixel_out    (ray_last_pixel_out)
    );

    initial begin
        pixel_clk_in = 1'b0;
        forever #10 pixel_clk_in = ~pixel_clk_in;               // 50 MHz
    end

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r[15:0]) % (hi - lo + 1);
    endfunction

    function automatic logic [REC_W-1:0] make_record(input int hcount, input int height,
                                                     input int side, input int code,
                                                     input int wall_x);
        logic [REC_W-1:0] rec;
        rec = '0;
        rec[HCOUNT_LSB +: HCOUNT_W] = HCOUNT_W'(hcount);
        rec[HEIGHT_LSB +: HEIGHT_W] = HEIGHT_W'(height);
        rec[WALL_TYPE_BIT]          = side[0];
        rec[MAP_LSB +: MAP_W]       = MAP_W'(code);
        rec[WALLX_LSB +: WALLX_W]   = WALLX_W'(wall_x);
        return rec;
    endfunction

    function automatic logic [REC_W-1:0] rand_record();
        return make_record(rand_range(0, SCREEN_WIDTH - 1), rand_range(1, SCREEN_HEIGHT),
                           rand_range(0, 1), rand_range(0, 15), rand_range(0, 65535));
    endfunction

    // expected colour of one row, straight from the colour rules
    function automatic pixel_t ref_pixel(input int row, input int height, input int code,
                                         input bit side, input int wall_x);
        int     ds;
        int     de;
        int     u;
        int     v;
        bit     in_span;
        pixel_t colour;
        ds      = SCREEN_HEIGHT / 2 - height / 2;
        de      = SCREEN_HEIGHT / 2 + height / 2;
        in_span = (row >= ds) && (row < de);
        u       = (wall_x >> 12) & 15;
        v       = (row - ds) % 16;                              // tiles every 16 rows
        if (!in_span)
            colour = BACKGROUND_COLOR;
        else if (code >= 3 && code <= 5)
            colour = pixel_t'((code - 3) * 4096 + u * 256 + v * 16 + (u ^ v));
        else if (code == 1)
            colour = BLACK_WALL;
        else if (code == 2)
            colour = GREEN_WALL;
        else
            colour = BACKGROUND_COLOR;
        if (side && in_span && code != 0)
            colour = (colour >> 1) & SHADE_MASK;                // y side is darker
        return colour;
    endfunction

    task automatic expect_column(input logic [REC_W-1:0] rec, input bit last);
        int hcount;
        int height;
        int code;
        int wall_x;
        bit side;
        hcount = int'(rec[HCOUNT_LSB +: HCOUNT_W]);
        height = int'(rec[HEIGHT_LSB +: HEIGHT_W]);
        code   = int'(rec[MAP_LSB +: MAP_W]);
        wall_x = int'(rec[WALLX_LSB +: WALLX_W]);
        side   = rec[WALL_TYPE_BIT];
        for (int r = 0; r < SCREEN_HEIGHT; r++) begin
            exp_addr.push_back(addr_t'(hcount + r * SCREEN_WIDTH));
            exp_pix.push_back(ref_pixel(r, height, code, side, wall_x));
            exp_last.push_back(last && (r == SCREEN_HEIGHT - 1));
        end
    endtask

    // offer one record until taken; swap_hold = offered cycles with swap ready low
    task automatic send_record(input logic [REC_W-1:0] rec, input bit last, input int swap_hold);
        int held;
        bit taken;
        held               = 0;
        taken              = 1'b0;
        dda_fifo_tdata_in  = rec;
        dda_fifo_tlast_in  = last;
        dda_fifo_tvalid_in = 1'b1;
        while (!taken) begin
            if (waiting_frame)
                fb_swap_ready_in = (held >= swap_hold);
            if (transformer_tready_out && (!waiting_frame || fb_swap_ready_in)) begin
                taken = 1'b1;                                   // taken at the coming edge
            end else begin
                if (transformer_tready_out)
                    held++;
                @(posedge pixel_clk_in);
                #1;
            end
        end
        expect_column(rec, last);
        @(posedge pixel_clk_in);
        #1;
        dda_fifo_tvalid_in = 1'b0;
        dda_fifo_tlast_in  = 1'b0;
        dda_fifo_tdata_in  = rand_record();                     // junk while idle
        fb_swap_ready_in   = 1'b0;
        waiting_frame      = last;
    endtask

    // gap with tready high and tvalid low, after the current column is out
    task automatic idle(input int cycles);
        while (!transformer_tready_out) begin
            @(posedge pixel_clk_in);
            #1;
        end
        repeat (cycles) begin
            dda_fifo_tdata_in = rand_record();                  // must be ignored with tvalid low
            @(posedge pixel_clk_in);
            #1;
        end
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            pix_errors++;
            $display("** Error: ray_pixel_out got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            addr_errors++;
            $display("** Error: ray_address_out got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_last(input bit got, input bit exp);
        if (got !== exp) begin
            last_errors++;
            $display("** Error: ray_last_pixel_out got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    // outputs sampled mid cycle, away from the rising edge
    always @(negedge pixel_clk_in) begin
        if (!rst_in && ray_valid_out) begin
            if (exp_addr.size() == 0) begin
                other_errors++;
                $display("pixel write to address %h with no write expected at %0t",
                         ray_address_out, $time);
            end else begin
                check_addr(ray_address_out, exp_addr.pop_front());
                check_pixel(ray_pixel_out, exp_pix.pop_front());
                check_last(ray_last_pixel_out, exp_last.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pixel_clk_in);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int flat_codes [5] = '{0, 1, 2, 7, 12};
        rst_in             = 1'b1;
        dda_fifo_tvalid_in = 1'b0;
        dda_fifo_tdata_in  = '0;
        dda_fifo_tlast_in  = 1'b0;
        fb_swap_ready_in   = 1'b0;
        repeat (2) @(posedge pixel_clk_in);
        #1;
        rst_in = 1'b0;

        foreach (flat_codes[i]) begin                          // flat and out of range codes
            send_record(make_record(col, rand_range(2, SCREEN_HEIGHT), 0, flat_codes[i],
                                    rand_range(0, 65535)), 1'b0, 0);
            col++;
        end
        for (int code = 3; code <= 5; code++) begin            // spans over 16 rows wrap v
            repeat (2) begin
                send_record(make_record(col, rand_range(18, SCREEN_HEIGHT), 0, code,
                                        rand_range(0, 65535)), 1'b0, 0);
                col++;
            end
        end
        for (int code = 0; code < 8; code++) begin             // y side shading
            send_record(make_record(col, rand_range(4, SCREEN_HEIGHT), 1, code,
                                    rand_range(0, 65535)), 1'b0, 0);
            col++;
        end
        repeat (6) send_record(rand_record(), 1'b0, 0);        // back to back columns

        send_record(rand_record(), 1'b1, 0);                   // frame end
        send_record(rand_record(), 1'b0, 6);
        send_record(rand_record(), 1'b1, 0);
        send_record(rand_record(), 1'b0, 3);

        repeat (8) begin                                       // idle gaps between columns
            idle(rand_range(1, 4));
            send_record(rand_record(), 1'b0, 0);
        end

        while (exp_addr.size() != 0) @(posedge pixel_clk_in);
        repeat (8) @(posedge pixel_clk_in);                    // catch any extra writes

        $display("errors: pixel %0d address %0d last %0d other %0d",
                 pix_errors, addr_errors, last_errors, other_errors);
        if (pix_errors + addr_errors + last_errors + other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* column_render.f */
source/raycast_pkg.sv
source/column_sequencer.sv
source/flat_shader.sv
source/texture_sampler.sv
source/pixel_merge.sv
source/column_render_top.sv
tests/column_render_chk.sv
tests/column_render_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module column_render_tb \
    -f column_render.f -o column_render_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/column_render_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
